/* hdl/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // ********************
    // Instruction formats
    // ********************
    typedef union packed {
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [4:0]        sa;
            logic [5:0]        funct;
        } r;
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [15:0]       imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FUNCT_SLL  = 6'h00;
    localparam logic [5:0] FUNCT_SRL  = 6'h02;
    localparam logic [5:0] FUNCT_SRA  = 6'h03;
    localparam logic [5:0] FUNCT_SLLV = 6'h04;
    localparam logic [5:0] FUNCT_SRLV = 6'h06;
    localparam logic [5:0] FUNCT_SRAV = 6'h07;
    localparam logic [5:0] FUNCT_JR   = 6'h08;
    localparam logic [5:0] FUNCT_JALR = 6'h09;
    localparam logic [5:0] FUNCT_MOVZ = 6'h0a;
    localparam logic [5:0] FUNCT_MOVN = 6'h0b;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_NOR  = 6'h27;

    localparam logic [REG_AW-1:0] RT_BLTZ   = 5'h00;
    localparam logic [REG_AW-1:0] RT_BGEZ   = 5'h01;
    localparam logic [REG_AW-1:0] RT_BLTZAL = 5'h10;
    localparam logic [REG_AW-1:0] RT_BGEZAL = 5'h11;

    localparam logic [3:0] ALU_OR  = 4'd0;
    localparam logic [3:0] ALU_AND = 4'd1;
    localparam logic [3:0] ALU_XOR = 4'd2;
    localparam logic [3:0] ALU_NOR = 4'd3;
    localparam logic [3:0] ALU_SLL = 4'd4;
    localparam logic [3:0] ALU_SRL = 4'd5;
    localparam logic [3:0] ALU_SRA = 4'd6;
    localparam logic [3:0] ALU_ADD = 4'd7;

    localparam logic [1:0] SRC_RT  = 2'd0;
    localparam logic [1:0] SRC_IMM = 2'd1;
    localparam logic [1:0] SRC_SA  = 2'd2;
    localparam logic [1:0] SRC_PC  = 2'd3; // PC plus 4, used for links.

    // Nine kinds, so the field is four bits wide.
    localparam logic [3:0] BR_NONE = 4'd0;
    localparam logic [3:0] BR_EQ   = 4'd1;
    localparam logic [3:0] BR_NE   = 4'd2;
    localparam logic [3:0] BR_GTZ  = 4'd3;
    localparam logic [3:0] BR_LEZ  = 4'd4;
    localparam logic [3:0] BR_LTZ  = 4'd5;
    localparam logic [3:0] BR_GEZ  = 4'd6;
    localparam logic [3:0] BR_JUMP = 4'd7;
    localparam logic [3:0] BR_JREG = 4'd8;

    localparam logic [REG_AW-1:0] LINK_REG = 5'd31;

endpackage

/* hdl/instr_decoder.sv */
module instr_decoder (
    input  mips_pkg::instr_t                i_instr,
    input  logic [mips_pkg::XLEN-1:0]       i_rt_value,
    output logic [mips_pkg::REG_AW-1:0]     o_raddr1,
    output logic [mips_pkg::REG_AW-1:0]     o_raddr2,
    output logic [mips_pkg::REG_AW-1:0]     o_waddr,
    output logic [mips_pkg::XLEN-1:0]       o_imm,
    output logic [3:0]                      o_alu_op,
    output logic [1:0]                      o_alu_src,
    output logic                            o_reg_wr,
    output logic [3:0]                      o_br_kind
);
    import mips_pkg::*;

    logic              wr;
    logic              link;
    logic [XLEN-1:0]   imm_zx;

    assign imm_zx = {16'h0000, i_instr.i.imm}; // Logic immediates are zero-extended.

    always_comb begin
        o_raddr1  = i_instr.r.rs;
        o_raddr2  = i_instr.r.rt;
        o_waddr   = i_instr.i.rt;
        o_imm     = '0;
        o_alu_op  = ALU_OR;
        o_alu_src = SRC_IMM;
        o_br_kind = BR_NONE;
        wr        = 1'b0;
        link      = 1'b0;
        case (i_instr.r.opcode)
            OP_ORI: begin
                wr    = 1'b1;
                o_imm = imm_zx;
            end
            OP_ANDI: begin
                wr       = 1'b1;
                o_imm    = imm_zx;
                o_alu_op = ALU_AND;
            end
            OP_XORI: begin
                wr       = 1'b1;
                o_imm    = imm_zx;
                o_alu_op = ALU_XOR;
            end
            OP_LUI: begin
                wr       = 1'b1;
                o_raddr1 = '0; // OR with zero.
                o_imm    = {i_instr.i.imm, 16'h0000};
            end
            OP_J:    o_br_kind = BR_JUMP;
            OP_JAL: begin
                o_br_kind = BR_JUMP;
                link      = 1'b1;
            end
            OP_BEQ:  o_br_kind = BR_EQ;
            OP_BNE:  o_br_kind = BR_NE;
            OP_BGTZ: o_br_kind = BR_GTZ;
            OP_BLEZ: o_br_kind = BR_LEZ;
            OP_REGIMM: begin
                case (i_instr.i.rt)
                    RT_BLTZ: o_br_kind = BR_LTZ;
                    RT_BGEZ: o_br_kind = BR_GEZ;
                    RT_BLTZAL: begin
                        o_br_kind = BR_LTZ;
                        link      = 1'b1;
                    end
                    RT_BGEZAL: begin
                        o_br_kind = BR_GEZ;
                        link      = 1'b1;
                    end
                    default: o_br_kind = BR_NONE;
                endcase
            end
            OP_SPECIAL: begin
                o_waddr = i_instr.r.rd;
                case (i_instr.r.funct)
                    FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_NOR: begin
                        wr        = 1'b1;
                        o_alu_src = SRC_RT;
                        case (i_instr.r.funct)
                            FUNCT_AND: o_alu_op = ALU_AND;
                            FUNCT_XOR: o_alu_op = ALU_XOR;
                            FUNCT_NOR: o_alu_op = ALU_NOR;
                            default:   o_alu_op = ALU_OR;
                        endcase
                    end
                    FUNCT_SLL, FUNCT_SRL, FUNCT_SRA: begin
                        wr        = 1'b1;
                        o_alu_src = SRC_SA;
                        o_alu_op  = ALU_SLL + {2'b00, i_instr.r.funct[1:0]} -
                                    {3'b000, i_instr.r.funct[1]};
                    end
                    FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV: begin
                        wr        = 1'b1;
                        o_alu_src = SRC_RT;
                        o_alu_op  = ALU_SLL + {2'b00, i_instr.r.funct[1:0]} -
                                    {3'b000, i_instr.r.funct[1]};
                    end
                    FUNCT_MOVN: wr = (i_rt_value != '0); // rs OR 0 moves rs.
                    FUNCT_MOVZ: wr = (i_rt_value == '0);
                    FUNCT_JR:   o_br_kind = BR_JREG;
                    FUNCT_JALR: begin
                        o_br_kind = BR_JREG;
                        wr        = 1'b1;
                        o_alu_src = SRC_PC;
                        o_alu_op  = ALU_ADD;
                    end
                    default: wr = 1'b0;
                endcase
            end
            default: wr = 1'b0;
        endcase
        if (link) begin
            wr        = 1'b1;
            o_waddr   = LINK_REG;
            o_alu_src = SRC_PC;
            o_alu_op  = ALU_ADD;
        end
        o_reg_wr = wr && (o_waddr != '0); // Register 0 is never written.
    end

    always_comb begin
        a_known_outputs: assert final ($isunknown({i_instr, i_rt_value}) ||
            !$isunknown({o_raddr1, o_raddr2, o_waddr, o_imm, o_alu_op, o_alu_src,
                         o_reg_wr, o_br_kind}));
    end

endmodule

/* hdl/reg_file.sv */
module reg_file (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic [mips_pkg::REG_AW-1:0]     i_raddr1,
    input  logic [mips_pkg::REG_AW-1:0]     i_raddr2,
    output logic [mips_pkg::XLEN-1:0]       o_rdata1,
    output logic [mips_pkg::XLEN-1:0]       o_rdata2,
    input  logic                            i_wb_en,
    input  logic [mips_pkg::REG_AW-1:0]     i_wb_addr,
    input  logic [mips_pkg::XLEN-1:0]       i_wb_data,
    input  logic                            i_wb_commit
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    // Pending write wins over the stored value.
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (i_wb_en && (i_wb_addr == addr))
            return i_wb_data;
        return regs[addr];
    endfunction

    assign o_rdata1 = read_port(i_raddr1);
    assign o_rdata2 = read_port(i_raddr2);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (i_wb_commit && (i_wb_addr != '0)) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    // Commit comes from the retire handshake, the enable from the decoded record.
    a_commit_en: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_commit |-> i_wb_en);

endmodule

/* hdl/next_pc_unit.sv */
module next_pc_unit #(
    parameter logic [mips_pkg::XLEN-1:0] P_RESET_PC = '0
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_advance,
    input  logic [3:0]                      i_br_kind,
    input  logic [mips_pkg::XLEN-1:0]       i_rs_value,
    input  logic [mips_pkg::XLEN-1:0]       i_rt_value,
    input  logic [15:0]                     i_imm_field,
    input  logic [25:0]                     i_target_field,
    output logic [mips_pkg::XLEN-1:0]       o_pc,
    output logic [mips_pkg::XLEN-1:0]       o_next_pc
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] br_target;
    logic            rs_zero;
    logic            taken;

    assign pc_plus4  = o_pc + 32'd4;
    assign br_target = pc_plus4 + {{14{i_imm_field[15]}}, i_imm_field, 2'b00};
    assign rs_zero   = (i_rs_value == '0);

    always_comb begin
        taken     = 1'b0;
        o_next_pc = pc_plus4;
        case (i_br_kind)
            BR_EQ:   taken = (i_rs_value == i_rt_value);
            BR_NE:   taken = (i_rs_value != i_rt_value);
            BR_GTZ:  taken = !i_rs_value[XLEN-1] && !rs_zero;
            BR_LEZ:  taken = i_rs_value[XLEN-1] || rs_zero;
            BR_LTZ:  taken = i_rs_value[XLEN-1];
            BR_GEZ:  taken = !i_rs_value[XLEN-1];
            BR_JUMP: o_next_pc = {pc_plus4[XLEN-1:28], i_target_field, 2'b00};
            BR_JREG: o_next_pc = i_rs_value;
            default: taken = 1'b0;
        endcase
        if (taken)
            o_next_pc = br_target;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_pc <= P_RESET_PC;
        else if (i_advance)
            o_pc <= o_next_pc; // One step per accepted instruction.
    end

endmodule

/* hdl/alu.sv */
module alu (
    input  logic [3:0]                      i_op,
    input  logic [1:0]                      i_src,
    input  logic [mips_pkg::XLEN-1:0]       i_rs_value,
    input  logic [mips_pkg::XLEN-1:0]       i_rt_value,
    input  logic [mips_pkg::XLEN-1:0]       i_imm,
    input  logic [4:0]                      i_sa,
    input  logic [mips_pkg::XLEN-1:0]       i_pc,
    output logic [mips_pkg::XLEN-1:0]       o_result
);
    import mips_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    // ********************
    // Operand select
    // ********************
    always_comb begin
        op_a  = (i_src == SRC_PC) ? i_pc : i_rs_value;
        shamt = (i_src == SRC_SA) ? i_sa : i_rs_value[4:0]; // Variable shifts use rs.
        case (i_src)
            SRC_IMM: op_b = i_imm;
            SRC_PC:  op_b = 32'd4;
            default: op_b = i_rt_value;
        endcase
    end

    always_comb begin
        case (i_op)
            ALU_AND: o_result = op_a & op_b;
            ALU_XOR: o_result = op_a ^ op_b;
            ALU_NOR: o_result = ~(op_a | op_b);
            ALU_SLL: o_result = i_rt_value << shamt;
            ALU_SRL: o_result = i_rt_value >> shamt;
            ALU_SRA: o_result = $signed(i_rt_value) >>> shamt;
            ALU_ADD: o_result = op_a + op_b;
            default: o_result = op_a | op_b;
        endcase
    end

endmodule

/* hdl/exec_stage.sv */
module exec_stage (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_load,
    input  logic [mips_pkg::XLEN-1:0]       i_pc,
    input  logic [mips_pkg::XLEN-1:0]       i_next_pc,
    input  logic [mips_pkg::XLEN-1:0]       i_rs_value,
    input  logic [mips_pkg::XLEN-1:0]       i_rt_value,
    input  logic [mips_pkg::XLEN-1:0]       i_imm,
    input  logic [4:0]                      i_sa,
    input  logic [3:0]                      i_alu_op,
    input  logic [1:0]                      i_alu_src,
    input  logic                            i_reg_wr,
    input  logic [mips_pkg::REG_AW-1:0]     i_waddr,
    output logic [mips_pkg::XLEN-1:0]       o_rs_value,
    output logic [mips_pkg::XLEN-1:0]       o_rt_value,
    output logic [mips_pkg::XLEN-1:0]       o_imm,
    output logic [4:0]                      o_sa,
    output logic [3:0]                      o_alu_op,
    output logic [1:0]                      o_alu_src,
    input  logic [mips_pkg::XLEN-1:0]       i_alu_result,
    input  logic                            i_ret_ready,
    output logic                            o_accept_ok,
    output logic                            o_wb_en,
    output logic [mips_pkg::REG_AW-1:0]     o_wb_addr,
    output logic [mips_pkg::XLEN-1:0]       o_wb_data,
    output logic                            o_wb_commit,
    output logic                            o_ret_valid,
    output logic [mips_pkg::XLEN-1:0]       o_ret_pc,
    output logic                            o_ret_wr,
    output logic [mips_pkg::REG_AW-1:0]     o_ret_waddr,
    output logic [mips_pkg::XLEN-1:0]       o_ret_wdata,
    output logic [mips_pkg::XLEN-1:0]       o_ret_next_pc
);

    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_ret_valid <= 1'b0;
        else if (i_load)
            o_ret_valid <= 1'b1;
        else if (i_ret_ready)
            o_ret_valid <= 1'b0;
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_ret_pc      <= i_pc;
            o_ret_next_pc <= i_next_pc;
            o_rs_value    <= i_rs_value;
            o_rt_value    <= i_rt_value;
            o_imm         <= i_imm;
            o_sa          <= i_sa;
            o_alu_op      <= i_alu_op;
            o_alu_src     <= i_alu_src;
            o_ret_wr      <= i_reg_wr;
            o_ret_waddr   <= i_waddr;
        end
    end

    assign o_accept_ok = !o_ret_valid || i_ret_ready; // Empty, or leaving this edge.
    assign o_ret_wdata = i_alu_result;

    // Write-back rides on the retire handshake.
    assign o_wb_en     = o_ret_valid && o_ret_wr;
    assign o_wb_addr   = o_ret_waddr;
    assign o_wb_data   = i_alu_result;
    assign o_wb_commit = o_wb_en && i_ret_ready;

    a_record_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_ret_valid && !i_ret_ready) |=> (o_ret_valid &&
            $stable({o_ret_pc, o_ret_wr, o_ret_waddr, o_ret_wdata, o_ret_next_pc})));

endmodule

/* hdl/mips_core.sv */
module mips_core #(
    parameter logic [mips_pkg::XLEN-1:0] P_RESET_PC = '0
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_instr_valid,
    input  mips_pkg::instr_t                i_instr,
    output logic                            o_instr_ready,
    input  logic                            i_ret_ready,
    output logic                            o_ret_valid,
    output logic                            o_ret_wr,
    output logic [mips_pkg::XLEN-1:0]       o_ret_pc,
    output logic [mips_pkg::XLEN-1:0]       o_ret_wdata,
    output logic [mips_pkg::XLEN-1:0]       o_ret_next_pc,
    output logic [mips_pkg::REG_AW-1:0]     o_ret_waddr
);
    import mips_pkg::*;

    logic [REG_AW-1:0] raddr1, raddr2, waddr, wb_addr;
    logic [XLEN-1:0]   rdata1, rdata2, imm, pc, next_pc, wb_data, alu_result;
    logic [XLEN-1:0]   ex_rs, ex_rt, ex_imm;
    logic [3:0]        alu_op, ex_alu_op, br_kind;
    logic [1:0]        alu_src, ex_alu_src;
    logic [4:0]        ex_sa;
    logic              reg_wr, accept_ok, load, wb_en, wb_commit;

    assign o_instr_ready = accept_ok;
    assign load          = i_instr_valid && accept_ok;

    // ********************
    // Decode
    // ********************
    instr_decoder instr_decoder_i (
        .i_instr(i_instr), .i_rt_value(rdata2), .o_raddr1(raddr1), .o_raddr2(raddr2),
        .o_waddr(waddr), .o_imm(imm), .o_alu_op(alu_op), .o_alu_src(alu_src),
        .o_reg_wr(reg_wr), .o_br_kind(br_kind)
    );

    reg_file reg_file_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_raddr1(raddr1), .i_raddr2(raddr2),
        .o_rdata1(rdata1), .o_rdata2(rdata2), .i_wb_en(wb_en), .i_wb_addr(wb_addr),
        .i_wb_data(wb_data), .i_wb_commit(wb_commit)
    );

    next_pc_unit #(.P_RESET_PC(P_RESET_PC)) next_pc_unit_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_advance(load), .i_br_kind(br_kind),
        .i_rs_value(rdata1), .i_rt_value(rdata2), .i_imm_field(i_instr.i.imm),
        .i_target_field(i_instr.j.target), .o_pc(pc), .o_next_pc(next_pc)
    );

    // ********************
    // Execute and retire
    // ********************
    exec_stage exec_stage_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_load(load), .i_pc(pc), .i_next_pc(next_pc),
        .i_rs_value(rdata1), .i_rt_value(rdata2), .i_imm(imm), .i_sa(i_instr.r.sa),
        .i_alu_op(alu_op), .i_alu_src(alu_src), .i_reg_wr(reg_wr), .i_waddr(waddr),
        .o_rs_value(ex_rs), .o_rt_value(ex_rt), .o_imm(ex_imm), .o_sa(ex_sa),
        .o_alu_op(ex_alu_op), .o_alu_src(ex_alu_src), .i_alu_result(alu_result),
        .i_ret_ready(i_ret_ready), .o_accept_ok(accept_ok), .o_wb_en(wb_en),
        .o_wb_addr(wb_addr), .o_wb_data(wb_data), .o_wb_commit(wb_commit),
        .o_ret_valid(o_ret_valid), .o_ret_pc(o_ret_pc), .o_ret_wr(o_ret_wr),
        .o_ret_waddr(o_ret_waddr), .o_ret_wdata(o_ret_wdata), .o_ret_next_pc(o_ret_next_pc)
    );

    alu alu_i (
        .i_op(ex_alu_op), .i_src(ex_alu_src), .i_rs_value(ex_rs), .i_rt_value(ex_rt),
        .i_imm(ex_imm), .i_sa(ex_sa), .i_pc(o_ret_pc), .o_result(alu_result)
    );

endmodule

/* sim/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic [mips_pkg::XLEN-1:0]   pc;
    logic [mips_pkg::XLEN-1:0]   next_pc;
    logic                        wr;
    logic [mips_pkg::REG_AW-1:0] waddr;
    logic [mips_pkg::XLEN-1:0]   wdata;
} ret_rec_t;

logic [XLEN-1:0] model_regs [32] = '{default: '0};
logic [XLEN-1:0] model_pc = RESET_PC;
ret_rec_t        exp_q [$];

// Architectural effect of one accepted instruction, no delay slot.
function automatic void model_step(input instr_t w);
    logic [XLEN-1:0] rs_v;
    logic [XLEN-1:0] rt_v;
    logic [XLEN-1:0] pc4;
    logic            taken;
    logic            link;
    ret_rec_t        rec;
    rs_v  = model_regs[w.r.rs];
    rt_v  = model_regs[w.r.rt];
    pc4   = model_pc + 32'd4;
    taken = 1'b0;
    link  = 1'b0;
    rec   = '{pc: model_pc, next_pc: pc4, wr: 1'b0, waddr: w.i.rt, wdata: '0};
    case (w.r.opcode)
        OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
            rec.wr = 1'b1;
            case (w.r.opcode)
                OP_ORI:  rec.wdata = rs_v | XLEN'(w.i.imm);
                OP_ANDI: rec.wdata = rs_v & XLEN'(w.i.imm);
                OP_XORI: rec.wdata = rs_v ^ XLEN'(w.i.imm);
                default: rec.wdata = {w.i.imm, 16'h0000};
            endcase
        end
        OP_SPECIAL: begin
            rec.waddr = w.r.rd;
            rec.wr    = 1'b1;
            case (w.r.funct)
                FUNCT_AND:  rec.wdata = rs_v & rt_v;
                FUNCT_OR:   rec.wdata = rs_v | rt_v;
                FUNCT_XOR:  rec.wdata = rs_v ^ rt_v;
                FUNCT_NOR:  rec.wdata = ~(rs_v | rt_v);
                FUNCT_SLL:  rec.wdata = rt_v << w.r.sa;
                FUNCT_SRL:  rec.wdata = rt_v >> w.r.sa;
                FUNCT_SRA:  rec.wdata = XLEN'($signed(rt_v) >>> w.r.sa);
                FUNCT_SLLV: rec.wdata = rt_v << rs_v[4:0];
                FUNCT_SRLV: rec.wdata = rt_v >> rs_v[4:0];
                FUNCT_SRAV: rec.wdata = XLEN'($signed(rt_v) >>> rs_v[4:0]);
                FUNCT_MOVN: begin
                    rec.wdata = rs_v;
                    rec.wr    = (rt_v != 0);
                end
                FUNCT_MOVZ: begin
                    rec.wdata = rs_v;
                    rec.wr    = (rt_v == 0);
                end
                FUNCT_JR: begin
                    rec.wr      = 1'b0;
                    rec.next_pc = rs_v;
                end
                FUNCT_JALR: begin
                    rec.wdata   = pc4;
                    rec.next_pc = rs_v;
                end
                default: rec.wr = 1'b0;
            endcase
        end
        OP_BEQ:  taken = (rs_v == rt_v);
        OP_BNE:  taken = (rs_v != rt_v);
        OP_BGTZ: taken = ($signed(rs_v) > 0);
        OP_BLEZ: taken = ($signed(rs_v) <= 0);
        OP_REGIMM: begin
            case (w.i.rt)
                RT_BLTZ, RT_BLTZAL: taken = ($signed(rs_v) < 0);
                RT_BGEZ, RT_BGEZAL: taken = ($signed(rs_v) >= 0);
                default:            taken = 1'b0;
            endcase
            link = (w.i.rt == RT_BLTZAL) || (w.i.rt == RT_BGEZAL); // Links taken or not.
        end
        OP_J, OP_JAL: begin
            rec.next_pc = {pc4[31:28], w.j.target, 2'b00};
            link        = (w.r.opcode == OP_JAL);
        end
        default: rec.wr = 1'b0;
    endcase
    if (taken)
        rec.next_pc = pc4 + (XLEN'(signed'(w.i.imm)) << 2);
    if (link) begin
        rec.wr    = 1'b1;
        rec.waddr = LINK_REG;
        rec.wdata = pc4;
    end
    if (rec.waddr == '0)
        rec.wr = 1'b0; // Register 0 stays zero.
    if (rec.wr)
        model_regs[rec.waddr] = rec.wdata;
    model_pc = rec.next_pc;
    exp_q.push_back(rec);
endfunction

`endif

/* sim/tb_mips_core.sv */
module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0040_0000;
    localparam int              CLK_HALF   = 2;
    localparam int              RESET_LEN  = 16;
    localparam int              RANDOM_LEN = 200;

    logic              i_clk;
    logic              i_reset;
    logic              i_instr_valid;
    instr_t            i_instr;
    logic              o_instr_ready;
    logic              i_ret_ready;
    logic              o_ret_valid;
    logic              o_ret_wr;
    logic [XLEN-1:0]   o_ret_pc;
    logic [XLEN-1:0]   o_ret_wdata;
    logic [XLEN-1:0]   o_ret_next_pc;
    logic [REG_AW-1:0] o_ret_waddr;

    int     value_errors = 0;
    int     other_errors = 0;
    int     retired      = 0;
    int     plan_len     = 0;
    instr_t prog [$];

    `include "tb_ref_model.svh"

    mips_core #(.P_RESET_PC(RESET_PC)) mips_core_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_instr_valid(i_instr_valid),
        .i_instr(i_instr), .o_instr_ready(o_instr_ready), .i_ret_ready(i_ret_ready),
        .o_ret_valid(o_ret_valid), .o_ret_wr(o_ret_wr), .o_ret_pc(o_ret_pc),
        .o_ret_wdata(o_ret_wdata), .o_ret_next_pc(o_ret_next_pc), .o_ret_waddr(o_ret_waddr)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_HALF) i_clk = ~i_clk;
    end

    // ********************
    // Instruction assembly
    // ********************
    function automatic instr_t r_format(input logic [5:0] funct, input int rs, input int rt,
                                        input int rd, input int sa);
        instr_t w;
        w.r.opcode = OP_SPECIAL;
        w.r.rs     = REG_AW'(rs);
        w.r.rt     = REG_AW'(rt);
        w.r.rd     = REG_AW'(rd);
        w.r.sa     = 5'(sa);
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic instr_t i_format(input logic [5:0] op, input int rs, input int rt,
                                        input int imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rs     = REG_AW'(rs);
        w.i.rt     = REG_AW'(rt);
        w.i.imm    = 16'(imm);
        return w;
    endfunction

    function automatic instr_t j_format(input logic [5:0] op, input int target);
        instr_t w;
        w.j.opcode = op;
        w.j.target = 26'(target);
        return w;
    endfunction

    // Few registers, so neighbours often depend on each other.
    function automatic instr_t random_word();
        int rs;
        int rt;
        int rd;
        int imm;
        rs  = $urandom_range(0, 7);
        rt  = $urandom_range(0, 7);
        rd  = $urandom_range(0, 7);
        imm = $urandom_range(0, 16'hffff);
        case ($urandom_range(0, 7))
            0: return i_format(OP_ANDI + 6'($urandom_range(0, 3)), rs, rt, imm);
            1: return r_format(FUNCT_AND + 6'($urandom_range(0, 3)), rs, rt, rd, 0);
            2: return r_format(FUNCT_SLL + 6'($urandom_range(0, 7)), rs, rt, rd, imm); // Gaps are no-ops.
            3: return r_format(FUNCT_MOVZ + 6'($urandom_range(0, 1)), rs, rt, rd, 0);
            4: return i_format(OP_BEQ + 6'($urandom_range(0, 3)), rs, rt, imm);
            5: return i_format(OP_REGIMM, rs, $urandom_range(0, 1) * 16 + $urandom_range(0, 1), imm);
            6: return j_format(OP_J + 6'($urandom_range(0, 1)), $urandom());
            default: return r_format(FUNCT_JR + 6'($urandom_range(0, 1)), rs, 0, rd, 0);
        endcase
    endfunction

    task automatic build_program();
        prog.push_back(i_format(OP_ORI, 0, 1, 'h8001));
        prog.push_back(i_format(OP_ORI, 0, 2, 'h00f0));
        prog.push_back(i_format(OP_LUI, 0, 3, 'hf000));
        prog.push_back(i_format(OP_ORI, 3, 3, 'h1234));
        prog.push_back(i_format(OP_ANDI, 1, 4, 'h00ff));
        prog.push_back(i_format(OP_XORI, 1, 5, 'hffff));
        prog.push_back(i_format(OP_ORI, 1, 0, 'h0005));
        prog.push_back(r_format(FUNCT_AND, 1, 2, 6, 0));
        prog.push_back(r_format(FUNCT_OR, 1, 2, 7, 0));
        prog.push_back(r_format(FUNCT_XOR, 1, 3, 8, 0));
        prog.push_back(r_format(FUNCT_NOR, 1, 2, 9, 0));
        prog.push_back(r_format(FUNCT_OR, 1, 2, 0, 0));
        prog.push_back(r_format(FUNCT_SLL, 0, 3, 10, 4));
        prog.push_back(r_format(FUNCT_SRL, 0, 3, 11, 8));
        prog.push_back(r_format(FUNCT_SRA, 0, 3, 12, 8));
        prog.push_back(r_format(FUNCT_SLLV, 2, 1, 13, 0));
        prog.push_back(r_format(FUNCT_SRLV, 4, 3, 14, 0));
        prog.push_back(r_format(FUNCT_SRAV, 4, 3, 15, 0));
        prog.push_back(r_format(FUNCT_MOVN, 1, 2, 16, 0));
        prog.push_back(r_format(FUNCT_MOVN, 1, 0, 17, 0));
        prog.push_back(r_format(FUNCT_MOVZ, 1, 0, 18, 0));
        prog.push_back(r_format(FUNCT_MOVZ, 1, 2, 19, 0));
        prog.push_back(i_format(OP_BEQ, 1, 1, 3));
        prog.push_back(i_format(OP_BEQ, 1, 2, 3));
        prog.push_back(i_format(OP_BNE, 1, 2, -2));
        prog.push_back(i_format(OP_BNE, 1, 1, -2));
        for (int k = 0; k < 3; k++) begin
            prog.push_back(i_format(OP_BGTZ, k * 3 % 4, 0, 5)); // r0, r3 and r2.
            prog.push_back(i_format(OP_BLEZ, k * 3 % 4, 0, -7));
        end
        for (int k = 0; k < 4; k++) begin
            prog.push_back(i_format(OP_REGIMM, 3, k / 2 * 16 + k % 2, 9));
            prog.push_back(i_format(OP_REGIMM, 1, k / 2 * 16 + k % 2, -9));
        end
        prog.push_back(j_format(OP_J, 'h0123456));
        prog.push_back(j_format(OP_JAL, 'h3ffffff));
        prog.push_back(i_format(OP_ORI, 0, 20, 'h2000));
        prog.push_back(r_format(FUNCT_JR, 20, 0, 0, 0));
        prog.push_back(r_format(FUNCT_JALR, 20, 0, 21, 0));
        prog.push_back(r_format(FUNCT_JALR, 21, 0, 0, 0));
        prog.push_back(i_format(6'h3f, 1, 2, 'h1234));
        prog.push_back(r_format(6'h3f, 1, 2, 3, 0));
        repeat (RANDOM_LEN) prog.push_back(random_word());
    endtask

    // ********************
    // Stimulus
    // ********************
    task automatic send_instr(input instr_t word);
        int gap;
        gap = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3);
        if (gap > 0) begin
            i_instr_valid <= 1'b0;
            repeat (gap) @(posedge i_clk);
        end
        i_instr       <= word;
        i_instr_valid <= 1'b1;
        @(negedge i_clk);
        while (!o_instr_ready)
            @(negedge i_clk);
        model_step(word); // Accepted on the coming edge.
        @(posedge i_clk);
    endtask

    task automatic drive_ret_ready();
        forever begin
            @(posedge i_clk);
            i_ret_ready <= ($urandom_range(0, 3) != 0);
        end
    endtask

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
        if (got !== want) begin
            value_errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_reg(input string what, input logic got_wr,
                             input logic [REG_AW-1:0] got_addr, input logic want_wr,
                             input logic [REG_AW-1:0] want_addr);
        if (got_wr !== want_wr || (want_wr && got_addr !== want_addr)) begin
            value_errors++;
            $display("mismatch at %0t: %s is wr %b to r%0d, expected wr %b to r%0d",
                     $time, what, got_wr, got_addr, want_wr, want_addr);
        end
    endtask

    // Inputs only move on rising edges, so the falling edge sees the handshake.
    initial begin : compare_retire
        ret_rec_t want;
        forever begin
            @(negedge i_clk);
            if (!i_reset && o_ret_valid && i_ret_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("A record retired at %0t with no instruction outstanding.", $time);
                end else begin
                    want = exp_q.pop_front();
                    if (retired == 0)
                        check_word("first retire PC", o_ret_pc, RESET_PC);
                    check_word("retire PC", o_ret_pc, want.pc);
                    check_word("next PC", o_ret_next_pc, want.next_pc);
                    check_reg("register write", o_ret_wr, o_ret_waddr, want.wr, want.waddr);
                    if (want.wr)
                        check_word("write data", o_ret_wdata, want.wdata);
                end
                retired++;
            end
        end
    end

    initial begin : watchdog
        wait (plan_len != 0);
        repeat (RESET_LEN + plan_len * 20) @(posedge i_clk);
        $display("Timeout: the run did not finish within %0d cycles.",
                 RESET_LEN + plan_len * 20);
        $display("Simulation failed");
        $finish;
    end

    initial begin : run_test
        void'($urandom(26631));
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_ret_ready   = 1'b0;
        build_program();
        plan_len = prog.size();
        repeat (RESET_LEN) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        if (o_ret_valid !== 1'b0 || o_instr_ready !== 1'b1) begin
            other_errors++;
            $display("After reset the core is not idle and ready for an instruction.");
        end
        fork
            drive_ret_ready();
        join_none
        @(posedge i_clk);
        foreach (prog[k])
            send_instr(prog[k]);
        i_instr_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(negedge i_clk);
        repeat (4) @(posedge i_clk);
        if (retired != plan_len) begin
            other_errors++;
            $display("%0d records retired for %0d instructions sent.", retired, plan_len);
        end
        $display("Errors: %0d mismatches, %0d other failures.", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+sim
hdl/mips_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/next_pc_unit.sv
hdl/alu.sv
hdl/exec_stage.sv
hdl/mips_core.sv
sim/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_mips_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mips_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
